// ==== design/core_pkg.sv ====
// core datapath definitions
`default_nettype none

package core_pkg;

	localparam int xlen = 32;
	localparam int reg_count = 32;
	localparam int reg_idx_w = 5;

	localparam logic [6:0] op_rtype = 7'b0110011;
	localparam logic [6:0] op_itype = 7'b0010011;
	localparam logic [6:0] op_li = 7'b0000111;

	localparam logic [6:0] funct7_base = 7'b0000000;
	localparam logic [6:0] funct7_alt = 7'b0100000;
	localparam logic [6:0] funct7_rot = 7'b0001111;
	localparam logic [6:0] funct7_dotp = 7'b1111111;

	localparam int alu_op_w = 4;
	typedef logic [alu_op_w-1:0] alu_op_t;

	localparam alu_op_t alu_add = 4'b0000;
	localparam alu_op_t alu_sub = 4'b0001;
	localparam alu_op_t alu_sll = 4'b0010;
	localparam alu_op_t alu_slt = 4'b0011;
	localparam alu_op_t alu_sle = 4'b0100;
	localparam alu_op_t alu_xor = 4'b0101;
	localparam alu_op_t alu_sra = 4'b0110;
	localparam alu_op_t alu_srl = 4'b0111;
	localparam alu_op_t alu_lor = 4'b1000;
	localparam alu_op_t alu_land = 4'b1001;
	localparam alu_op_t alu_rotcw = 4'b1011; // rotate right
	localparam alu_op_t alu_rotacw = 4'b1100; // rotate left
	localparam alu_op_t alu_li = 4'b1101;
	localparam alu_op_t alu_dotp = 4'b1110;

	localparam logic [xlen-1:0] sat_pos = 32'h7fffffff;
	localparam logic [xlen-1:0] sat_neg = 32'h80000001; // not the most negative value

	// one instruction word read in R-form or I-form
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [reg_idx_w-1:0] rs2;
			logic [reg_idx_w-1:0] rs1;
			logic [2:0] funct3;
			logic [reg_idx_w-1:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [reg_idx_w-1:0] rs1;
			logic [2:0] funct3;
			logic [reg_idx_w-1:0] rd;
			logic [6:0] opcode;
		} i;
	} inst_word_t;

endpackage

`default_nettype wire

// ==== design/inst_decode.sv ====
// instruction decoder
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
	input wire inst_valid,
	input wire [core_pkg::xlen-1:0] inst_code,
	output logic dec_valid,
	output core_pkg::alu_op_t alu_op,
	output logic use_imm,
	output logic [core_pkg::xlen-1:0] imm,
	output logic [core_pkg::reg_idx_w-1:0] rs1,
	output logic [core_pkg::reg_idx_w-1:0] rs2,
	output logic [core_pkg::reg_idx_w-1:0] rd
);

	core_pkg::inst_word_t iw;
	logic known;

	assign iw = inst_code;

	// register fields sit at the same bits in both forms
	assign rs1 = iw.r.rs1;
	assign rs2 = iw.r.rs2;
	assign rd = iw.r.rd;
	assign imm = {{(core_pkg::xlen-12){iw.i.imm12[11]}}, iw.i.imm12};

	always_comb
	begin
		known = 1'b0;
		use_imm = 1'b0;
		alu_op = core_pkg::alu_add;
		case (iw.r.opcode)
			core_pkg::op_rtype:
			begin
				known = 1'b1;
				case ({iw.r.funct7, iw.r.funct3})
					{core_pkg::funct7_base, 3'b000}: alu_op = core_pkg::alu_add;
					{core_pkg::funct7_alt, 3'b000}: alu_op = core_pkg::alu_sub;
					{core_pkg::funct7_base, 3'b001}: alu_op = core_pkg::alu_sll;
					{core_pkg::funct7_alt, 3'b010}: alu_op = core_pkg::alu_slt;
					{core_pkg::funct7_base, 3'b011}: alu_op = core_pkg::alu_sle;
					{core_pkg::funct7_base, 3'b100}: alu_op = core_pkg::alu_xor;
					{core_pkg::funct7_base, 3'b101}: alu_op = core_pkg::alu_sra;
					{core_pkg::funct7_alt, 3'b101}: alu_op = core_pkg::alu_srl;
					{core_pkg::funct7_base, 3'b110}: alu_op = core_pkg::alu_lor;
					{core_pkg::funct7_base, 3'b111}: alu_op = core_pkg::alu_land;
					{core_pkg::funct7_rot, 3'b000}: alu_op = core_pkg::alu_rotcw;
					{core_pkg::funct7_rot, 3'b001}: alu_op = core_pkg::alu_rotacw;
					{core_pkg::funct7_dotp, 3'b000}: alu_op = core_pkg::alu_dotp;
					default: known = 1'b0;
				endcase
			end
			core_pkg::op_itype:
			begin
				known = 1'b1;
				use_imm = 1'b1;
				case (iw.i.funct3)
					3'b000: alu_op = core_pkg::alu_add;
					3'b001: alu_op = core_pkg::alu_sll;
					3'b010: alu_op = core_pkg::alu_slt;
					3'b011: alu_op = core_pkg::alu_sle;
					3'b100: alu_op = core_pkg::alu_xor;
					3'b101: alu_op = core_pkg::alu_sra;
					3'b110: alu_op = core_pkg::alu_lor;
					default: alu_op = core_pkg::alu_land;
				endcase
			end
			core_pkg::op_li:
			begin
				known = 1'b1;
				use_imm = 1'b1;
				alu_op = core_pkg::alu_li;
			end
			default: known = 1'b0;
		endcase
	end

	// r0 as destination means nothing to write back
	assign dec_valid = inst_valid && known && (rd != '0);

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
// 32 entry register file
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input wire clk,
	input wire res,
	input wire [core_pkg::reg_idx_w-1:0] rs1,
	input wire [core_pkg::reg_idx_w-1:0] rs2,
	input wire wr_en,
	input wire [core_pkg::reg_idx_w-1:0] wr_reg,
	input wire [core_pkg::xlen-1:0] wr_data,
	output logic [core_pkg::xlen-1:0] rd1_data,
	output logic [core_pkg::xlen-1:0] rd2_data
);

	logic [core_pkg::xlen-1:0] regs [core_pkg::reg_count];
	logic wr_live;

	assign wr_live = wr_en && (wr_reg != '0);

	// register n comes out of reset holding n
	always_ff @(posedge clk or negedge res)
	begin
		if (!res)
		begin
			for (int n = 0; n < core_pkg::reg_count; n++)
			begin
				regs[n] <= core_pkg::xlen'(n);
			end
		end
		else if (wr_live)
		begin
			regs[wr_reg] <= wr_data;
		end
	end

	// write-through for the instruction two ahead
	assign rd1_data = (wr_live && wr_reg == rs1) ? wr_data : regs[rs1];
	assign rd2_data = (wr_live && wr_reg == rs2) ? wr_data : regs[rs2];

endmodule

`default_nettype wire

// ==== design/alu.sv ====
// saturating integer alu
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire [core_pkg::xlen-1:0] a,
	input wire [core_pkg::xlen-1:0] b,
	input wire core_pkg::alu_op_t op,
	output logic [core_pkg::xlen-1:0] result,
	output logic sat
);

	logic [4:0] sh;
	logic [2*core_pkg::xlen-1:0] rot_r;
	logic [2*core_pkg::xlen-1:0] rot_l;
	logic [15:0] p0, p1, p2, p3;
	logic [17:0] dot_sum;
	logic [core_pkg::xlen-1:0] raw;
	logic sat_up;
	logic sat_dn;

	assign sh = b[4:0];
	assign rot_r = {a, a} >> sh; // low half
	assign rot_l = {a, a} << sh; // high half

	// unsigned byte lanes
	assign p0 = a[7:0] * b[7:0];
	assign p1 = a[15:8] * b[15:8];
	assign p2 = a[23:16] * b[23:16];
	assign p3 = a[31:24] * b[31:24];
	assign dot_sum = p0 + p1 + p2 + p3;

	always_comb
	begin
		raw = '0;
		case (op)
			core_pkg::alu_add: raw = a + b;
			core_pkg::alu_sub: raw = a - b;
			core_pkg::alu_sll: raw = a << sh;
			core_pkg::alu_slt: raw[0] = $signed(a) < $signed(b);
			core_pkg::alu_sle: raw[0] = $signed(a) <= $signed(b);
			core_pkg::alu_xor: raw = a ^ b;
			core_pkg::alu_sra: raw = $signed(a) >>> sh;
			core_pkg::alu_srl: raw = a >> sh;
			core_pkg::alu_lor: raw[0] = (a != '0) || (b != '0);
			core_pkg::alu_land: raw[0] = (a != '0) && (b != '0);
			core_pkg::alu_rotcw: raw = rot_r[core_pkg::xlen-1:0];
			core_pkg::alu_rotacw: raw = rot_l[2*core_pkg::xlen-1:core_pkg::xlen];
			core_pkg::alu_li: raw = b;
			core_pkg::alu_dotp: raw = {{(core_pkg::xlen-18){1'b0}}, dot_sum};
			default: raw = '0;
		endcase
	end

	// sign flip with like-signed operands on every op
	assign sat_up = !a[31] && (a != '0) && !b[31] && (b != '0) && raw[31];
	assign sat_dn = a[31] && b[31] && !raw[31] && (raw != '0);

	always_comb
	begin
		if (sat_up)
			result = core_pkg::sat_pos;
		else if (sat_dn)
			result = core_pkg::sat_neg;
		else
			result = raw;
	end

	assign sat = sat_up || sat_dn;

endmodule

`default_nettype wire

// ==== design/exec_stage.sv ====
// execute stage and pipeline registers
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
	input wire clk,
	input wire res,
	input wire dec_valid,
	input wire core_pkg::alu_op_t alu_op,
	input wire use_imm,
	input wire [core_pkg::xlen-1:0] imm,
	input wire [core_pkg::reg_idx_w-1:0] rs1,
	input wire [core_pkg::reg_idx_w-1:0] rs2,
	input wire [core_pkg::reg_idx_w-1:0] rd,
	input wire [core_pkg::xlen-1:0] rd1_data,
	input wire [core_pkg::xlen-1:0] rd2_data,
	output logic wb_valid,
	output logic [core_pkg::reg_idx_w-1:0] wb_reg,
	output logic [core_pkg::xlen-1:0] wb_data,
	output logic wb_sat
);

	logic ex_valid;
	core_pkg::alu_op_t ex_op;
	logic ex_use_imm;
	logic [core_pkg::xlen-1:0] ex_imm;
	logic [core_pkg::reg_idx_w-1:0] ex_rs1;
	logic [core_pkg::reg_idx_w-1:0] ex_rs2;
	logic [core_pkg::reg_idx_w-1:0] ex_rd;
	logic [core_pkg::xlen-1:0] ex_a;
	logic [core_pkg::xlen-1:0] ex_b;
	logic [core_pkg::xlen-1:0] op_a;
	logic [core_pkg::xlen-1:0] op_b_reg;
	logic [core_pkg::xlen-1:0] op_b;
	logic [core_pkg::xlen-1:0] alu_result;
	logic alu_sat;

	// id/ex
	always_ff @(posedge clk or negedge res)
	begin
		if (!res)
			ex_valid <= 1'b0;
		else
			ex_valid <= dec_valid;
	end

	always_ff @(posedge clk)
	begin
		ex_op <= alu_op;
		ex_use_imm <= use_imm;
		ex_imm <= imm;
		ex_rs1 <= rs1;
		ex_rs2 <= rs2;
		ex_rd <= rd;
		ex_a <= rd1_data;
		ex_b <= rd2_data;
	end

	// forward from the older instruction sitting in ex/wb
	assign op_a = (wb_valid && wb_reg == ex_rs1) ? wb_data : ex_a;
	assign op_b_reg = (wb_valid && wb_reg == ex_rs2) ? wb_data : ex_b;
	assign op_b = ex_use_imm ? ex_imm : op_b_reg;

	alu alu_inst (
		.a(op_a),
		.b(op_b),
		.op(ex_op),
		.result(alu_result),
		.sat(alu_sat)
	);

	// ex/wb
	always_ff @(posedge clk or negedge res)
	begin
		if (!res)
		begin
			wb_valid <= 1'b0;
			wb_sat <= 1'b0;
		end
		else
		begin
			wb_valid <= ex_valid;
			wb_sat <= ex_valid && alu_sat; // bubbles never flag
		end
	end

	always_ff @(posedge clk)
	begin
		wb_reg <= ex_rd;
		wb_data <= alu_result;
	end

endmodule

`default_nettype wire

// ==== design/core_top.sv ====
// three stage integer core
`timescale 1ns/1ps
`default_nettype none

module core_top (
	input wire clk,
	input wire res,
	input wire inst_valid,
	input wire [core_pkg::xlen-1:0] inst_code,
	output logic wb_valid,
	output logic [core_pkg::reg_idx_w-1:0] wb_reg,
	output logic [core_pkg::xlen-1:0] wb_data,
	output logic wb_sat
);

	logic dec_valid;
	core_pkg::alu_op_t alu_op;
	logic use_imm;
	logic [core_pkg::xlen-1:0] imm;
	logic [core_pkg::reg_idx_w-1:0] rs1;
	logic [core_pkg::reg_idx_w-1:0] rs2;
	logic [core_pkg::reg_idx_w-1:0] rd;
	logic [core_pkg::xlen-1:0] rd1_data;
	logic [core_pkg::xlen-1:0] rd2_data;

	inst_decode inst_decode_inst (
		.inst_valid(inst_valid),
		.inst_code(inst_code),
		.dec_valid(dec_valid),
		.alu_op(alu_op),
		.use_imm(use_imm),
		.imm(imm),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd)
	);

	// write port fed straight from the wb outputs
	reg_file reg_file_inst (
		.clk(clk),
		.res(res),
		.rs1(rs1),
		.rs2(rs2),
		.wr_en(wb_valid),
		.wr_reg(wb_reg),
		.wr_data(wb_data),
		.rd1_data(rd1_data),
		.rd2_data(rd2_data)
	);

	exec_stage exec_stage_inst (
		.clk(clk),
		.res(res),
		.dec_valid(dec_valid),
		.alu_op(alu_op),
		.use_imm(use_imm),
		.imm(imm),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.rd1_data(rd1_data),
		.rd2_data(rd2_data),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.wb_sat(wb_sat)
	);

endmodule

`default_nettype wire

// ==== bench/core_sva.sv ====
// writeback port assertions
`timescale 1ns/1ps
`default_nettype none

module core_sva (
	input wire clk,
	input wire res,
	input wire wb_valid,
	input wire [4:0] wb_reg,
	input wire [31:0] wb_data,
	input wire wb_sat
);

	sat_needs_valid: assert property (@(posedge clk) disable iff (!res) wb_sat |-> wb_valid)
		else $error("wb_sat high without wb_valid");

	no_r0_write: assert property (@(posedge clk) disable iff (!res) wb_valid |-> wb_reg != 5'd0)
		else $error("writeback to r0");

	sat_value: assert property (@(posedge clk) disable iff (!res)
		wb_sat |-> (wb_data == core_pkg::sat_pos || wb_data == core_pkg::sat_neg))
		else $error("saturated result is not a saturation value");

	// one edge after reset is seen the wb port must be idle
	idle_in_reset: assert property (@(posedge clk) !res |=> !wb_valid)
		else $error("wb_valid high during reset");

endmodule

bind core_top core_sva core_sva_inst (
	.clk(clk),
	.res(res),
	.wb_valid(wb_valid),
	.wb_reg(wb_reg),
	.wb_data(wb_data),
	.wb_sat(wb_sat)
);

`default_nettype wire

// ==== bench/core_tb.sv ====
// core pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	localparam int n_rand = 200;
	localparam int total_inst = 3 * n_rand + 250; // cycles incl. reset and drains

	typedef struct packed {
		logic [31:0] tag;
		logic [4:0] rd;
		logic [31:0] data;
		logic sat;
	} exp_t;

	logic clk = 1'b0;
	logic res;
	logic inst_valid;
	logic [31:0] inst_code;
	logic wb_valid;
	logic [4:0] wb_reg;
	logic [31:0] wb_data;
	logic wb_sat;

	int seed = 7584;
	int cyc = 0;
	int errors = 0;
	int err_mark = 0;
	int checks = 0;
	int tests = 0;
	int failed = 0;
	logic [31:0] model [32];
	exp_t q [$];

	// {funct7, funct3, alu op} in the order used by the random tests
	logic [13:0] r_tab [13] = '{
		{core_pkg::funct7_base, 3'd0, core_pkg::alu_add},
		{core_pkg::funct7_alt, 3'd0, core_pkg::alu_sub},
		{core_pkg::funct7_base, 3'd1, core_pkg::alu_sll},
		{core_pkg::funct7_alt, 3'd2, core_pkg::alu_slt},
		{core_pkg::funct7_base, 3'd3, core_pkg::alu_sle},
		{core_pkg::funct7_base, 3'd4, core_pkg::alu_xor},
		{core_pkg::funct7_base, 3'd5, core_pkg::alu_sra},
		{core_pkg::funct7_alt, 3'd5, core_pkg::alu_srl},
		{core_pkg::funct7_base, 3'd6, core_pkg::alu_lor},
		{core_pkg::funct7_base, 3'd7, core_pkg::alu_land},
		{core_pkg::funct7_rot, 3'd0, core_pkg::alu_rotcw},
		{core_pkg::funct7_rot, 3'd1, core_pkg::alu_rotacw},
		{core_pkg::funct7_dotp, 3'd0, core_pkg::alu_dotp}
	};
	core_pkg::alu_op_t i_ops [8] = '{core_pkg::alu_add, core_pkg::alu_sll, core_pkg::alu_slt,
		core_pkg::alu_sle, core_pkg::alu_xor, core_pkg::alu_sra, core_pkg::alu_lor,
		core_pkg::alu_land};

	core_top core_top_inst (
		.clk(clk),
		.res(res),
		.inst_valid(inst_valid),
		.inst_code(inst_code),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.wb_sat(wb_sat)
	);

	initial
	begin
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	// reference alu with the saturation rule
	task automatic alu_model(input logic [31:0] a, b, input core_pkg::alu_op_t op,
		output logic [31:0] r, output logic s);
		logic [31:0] raw;
		logic [4:0] sh;
		sh = b[4:0];
		case (op)
			core_pkg::alu_add: raw = a + b;
			core_pkg::alu_sub: raw = a - b;
			core_pkg::alu_sll: raw = a << sh;
			core_pkg::alu_slt: raw = ($signed(a) < $signed(b)) ? 1 : 0;
			core_pkg::alu_sle: raw = ($signed(a) <= $signed(b)) ? 1 : 0;
			core_pkg::alu_xor: raw = a ^ b;
			core_pkg::alu_sra: raw = $signed(a) >>> sh;
			core_pkg::alu_srl: raw = a >> sh;
			core_pkg::alu_lor: raw = (a != 0 || b != 0) ? 1 : 0;
			core_pkg::alu_land: raw = (a != 0 && b != 0) ? 1 : 0;
			core_pkg::alu_rotcw: raw = (a >> sh) | (a << (6'd32 - {1'b0, sh}));
			core_pkg::alu_rotacw: raw = (a << sh) | (a >> (6'd32 - {1'b0, sh}));
			core_pkg::alu_li: raw = b;
			core_pkg::alu_dotp: raw = 32'(a[7:0]) * 32'(b[7:0]) + 32'(a[15:8]) * 32'(b[15:8])
				+ 32'(a[23:16]) * 32'(b[23:16]) + 32'(a[31:24]) * 32'(b[31:24]);
			default: raw = 0;
		endcase
		r = raw;
		s = 1'b0;
		if ($signed(a) > 0 && $signed(b) > 0 && $signed(raw) < 0)
		begin
			r = core_pkg::sat_pos;
			s = 1'b1;
		end
		else if ($signed(a) < 0 && $signed(b) < 0 && $signed(raw) > 0)
		begin
			r = core_pkg::sat_neg;
			s = 1'b1;
		end
	endtask

	task automatic check_wb();
		exp_t e;
		checks++;
		if (q.size() > 0 && q[0].tag == cyc)
		begin
			e = q.pop_front();
			if (wb_valid !== 1'b1 || wb_reg !== e.rd || wb_data !== e.data || wb_sat !== e.sat)
			begin
				$display("error at %0t ns: expected r%0d=%h sat %b, got valid %b r%0d=%h sat %b",
					$time, e.rd, e.data, e.sat, wb_valid, wb_reg, wb_data, wb_sat);
				errors++;
			end
		end
		else if (wb_valid !== 1'b0)
		begin
			$display("error at %0t ns: unexpected writeback r%0d=%h", $time, wb_reg, wb_data);
			errors++;
		end
	endtask

	// check the wb port, then drive the next word and update the model
	task automatic issue(input logic v, input logic [31:0] code, input logic known,
		input core_pkg::alu_op_t op, input logic use_imm);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic s;
		exp_t e;
		@(negedge clk);
		check_wb();
		inst_valid = v;
		inst_code = code;
		a = model[code[19:15]];
		b = use_imm ? {{20{code[31]}}, code[31:20]} : model[code[24:20]];
		alu_model(a, b, op, r, s);
		if (v && known && code[11:7] != 5'd0)
		begin
			model[code[11:7]] = r;
			e.tag = cyc + 2;
			e.rd = code[11:7];
			e.data = r;
			e.sat = s;
			q.push_back(e);
		end
		cyc++;
	endtask

	task automatic issue_r(input int k, input logic [4:0] rd, rs1, rs2);
		logic [13:0] t;
		t = r_tab[k];
		issue(1'b1, {t[13:7], rs2, rs1, t[6:4], rd, core_pkg::op_rtype}, 1'b1, t[3:0], 1'b0);
	endtask

	task automatic issue_i(input logic [2:0] f3, input logic [4:0] rd, rs1,
		input logic [11:0] imm);
		issue(1'b1, {imm, rs1, f3, rd, core_pkg::op_itype}, 1'b1, i_ops[f3], 1'b1);
	endtask

	task automatic issue_li(input logic [4:0] rd, rs1, input logic [11:0] imm);
		issue(1'b1, {imm, rs1, 3'b000, rd, core_pkg::op_li}, 1'b1, core_pkg::alu_li, 1'b1);
	endtask

	task automatic finish_test(input string name);
		repeat (3) issue(1'b0, '0, 1'b0, core_pkg::alu_add, 1'b0); // drain
		tests++;
		if (errors != err_mark)
			failed++;
		$display("test %0d %s: %s (%0d errors)", tests, name,
			(errors == err_mark) ? "pass" : "fail", errors - err_mark);
		err_mark = errors;
	endtask

	task automatic readback();
		for (int n = 1; n < 32; n++)
			issue_r(0, 5'(n), 5'(n), 5'd0);
	endtask

	initial
	begin
		#((total_inst + 50) * 100);
		$display("timeout: the run did not finish within the expected time");
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] r;
		logic [4:0] rd;
		logic [4:0] h1;
		logic [4:0] h2;
		logic [6:0] opc;
		res = 1'b0;
		inst_valid = 1'b0;
		inst_code = '0;
		for (int n = 0; n < 32; n++)
			model[n] = 32'(n);
		repeat (16) @(posedge clk);
		@(negedge clk);
		res = 1'b1;

		for (int n = 0; n < 32; n++)
			issue_r(0, 5'(n), 5'(n), 5'd0); // n=0 writes r0 and gives no wb
		finish_test("reset preload");

		for (int j = 0; j < n_rand; j++)
		begin
			r = rnd();
			issue_r(int'(r[31:16] % 16'd13), r[4:0], r[9:5], r[14:10]);
		end
		finish_test("random R-type");

		for (int j = 0; j < n_rand; j++)
		begin
			r = rnd();
			if (r[31:30] == 2'b00)
				issue_li(r[4:0], r[9:5], r[26:15]);
			else
				issue_i(r[29:27], r[4:0], r[9:5], r[26:15]);
		end
		finish_test("random I-type and li");

		h1 = 5'd1;
		h2 = 5'd2;
		for (int j = 0; j < n_rand; j++)
		begin
			r = rnd();
			rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
			if (r[7])
				issue_r(int'(r[31:28] % 4'd13), rd, r[5] ? h1 : h2, r[6] ? h2 : h1);
			else
				issue_i(r[10:8], rd, r[5] ? h1 : h2, r[27:16]);
			h2 = h1;
			h1 = rd;
		end
		finish_test("dependent chains");

		issue_li(5'd1, 5'd0, 12'hfff); // -1
		issue_li(5'd2, 5'd0, 12'h001);
		issue_r(7, 5'd3, 5'd1, 5'd2); // 7fffffff
		issue_r(5, 5'd4, 5'd3, 5'd1); // 80000000
		issue_r(0, 5'd5, 5'd3, 5'd2);
		issue_r(0, 5'd6, 5'd4, 5'd1);
		for (int j = 0; j < 60; j++)
		begin
			r = rnd();
			rd = 5'd5 + 5'(r[11:8] % 4'd11);
			issue_r(r[12] ? 1 : 0, rd, {1'b0, r[3:0]}, {1'b0, r[7:4]});
		end
		finish_test("saturation");

		for (int j = 0; j < 40; j++)
		begin
			r = rnd();
			case (r[1:0])
				2'd0:
				begin
					opc = r[8:2];
					if (opc == core_pkg::op_rtype || opc == core_pkg::op_itype ||
						opc == core_pkg::op_li)
						opc = opc ^ 7'h40;
					issue(1'b1, {r[31:7], opc}, 1'b0, core_pkg::alu_add, 1'b0);
				end
				2'd1: issue(1'b1, {7'b0000001, r[24:12], r[4:0] | 5'd1, core_pkg::op_rtype},
					1'b0, core_pkg::alu_add, 1'b0);
				2'd2: issue_r(int'(r[31:28] % 4'd13), 5'd0, r[9:5], r[14:10]);
				default: issue(1'b0, {r[31:15], 3'b000, 5'd9, core_pkg::op_itype},
					1'b1, core_pkg::alu_add, 1'b1);
			endcase
		end
		readback();
		finish_test("illegal and idle words");

		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			tests, failed, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
design/core_pkg.sv
design/inst_decode.sv
design/reg_file.sv
design/alu.sv
design/exec_stage.sv
design/core_top.sv
bench/core_sva.sv
bench/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module core_tb -o core_sim
./obj_dir/core_sim | tee sim.log

if grep -q "TEST FAILED" sim.log
then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
